// File: all.f
fp_format_pkg.sv
fp_add_pkg.sv
fp_align.sv
prefix_adder.sv
fp_normalize_round.sv
fp_adder.sv
tb_fp_adder.sv

// File: Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_fp_adder -f all.f --Mdir obj_dir
	./obj_dir/Vtb_fp_adder | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: tb_fp_adder.sv
// Testbench for the pipelined FP adder against a wide integer reference model
`timescale 1ns/1ns

module tb_fp_adder;

	logic clk;
	logic rst;
	logic in_valid;
	logic [31:0] in_a, in_b;
	logic in_sub;
	logic out_valid;
	logic [31:0] out_result;

	// Expected results in issue order
	logic [31:0] exp_q[$];
	string name_q[$];
	int edges;
	logic seen;
	logic [31:0] seed, x, y;

	fp_adder fp_adder_inst (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.in_a(in_a),
		.in_b(in_b),
		.in_sub(in_sub),
		.out_valid(out_valid),
		.out_result(out_result)
	);

	always #20 clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
			$display("Test failed");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	function automatic longint unsigned shift_sticky(input longint unsigned w, input int d);
		if (d >= 50)
			return (w != 0) ? 64'd1 : 64'd0;
		return (w >> d) | (((w & ((64'd1 << d) - 1)) != 0) ? 64'd1 : 64'd0);
	endfunction

	// IEEE binary32 add rounding to nearest even with denormals and tiny results as zero
	function automatic logic [31:0] expected_result(input logic [31:0] a, input logic [31:0] b,
			input logic sub);
		logic sa, sb, sr;
		logic [7:0] ea, eb, el;
		logic [22:0] fa, fb;
		longint unsigned wa, wb, mag, mant, rem, half;
		longint va, vb, sum;
		int d, p, s, e;
		sa = a[31];
		ea = a[30:23];
		fa = a[22:0];
		sb = b[31] ^ sub;
		eb = b[30:23];
		fb = b[22:0];
		if ((ea == 8'hff && fa != 0) || (eb == 8'hff && fb != 0))
			return 32'h7fc00000;
		if (ea == 8'hff && eb == 8'hff)
			return (sa == sb) ? {sa, 8'hff, 23'd0} : 32'h7fc00000;
		if (ea == 8'hff)
			return {sa, 8'hff, 23'd0};
		if (eb == 8'hff)
			return {sb, 8'hff, 23'd0};
		if (ea == 0 && eb == 0)
			return {sa & sb, 31'd0};
		if (ea == 0)
			return {sb, eb, fb};
		if (eb == 0)
			return {sa, ea, fa};
		// Hidden bit at position 49 with 26 spare bits below the fraction
		wa = {40'd0, 1'b1, fa} << 26;
		wb = {40'd0, 1'b1, fb} << 26;
		d = int'(ea) - int'(eb);
		if (d >= 0) begin
			el = ea;
			wb = shift_sticky(wb, d);
		end else begin
			el = eb;
			wa = shift_sticky(wa, -d);
		end
		va = wa;
		vb = wb;
		if (sa)
			va = -va;
		if (sb)
			vb = -vb;
		sum = va + vb;
		if (sum == 0)
			return 32'h0;
		sr = (sum < 0);
		mag = sr ? -sum : sum;
		p = 0;
		for (int k = 0; k < 64; k++) begin
			if (mag[k])
				p = k;
		end
		s = p - 23;
		mant = mag >> s;
		rem = mag & ((64'd1 << s) - 1);
		half = 64'd1 << (s - 1);
		if (rem > half || (rem == half && mant[0]))
			mant = mant + 1;
		e = int'(el) + p - 49;
		if (mant[24]) begin
			mant = mant >> 1;
			e = e + 1;
		end
		if (e >= 255)
			return {sr, 8'hff, 23'd0};
		if (e <= 0)
			return {sr, 31'd0};
		return {sr, e[7:0], mant[22:0]};
	endfunction

	function automatic logic [31:0] random_normal();
		return {1'($urandom), 8'($urandom_range(254, 1)), 23'($urandom)};
	endfunction

	// Random normal with exponent offset from a by lo to hi
	function automatic logic [31:0] random_offset(input logic [31:0] a, input int lo, input int hi);
		int e;
		e = int'(a[30:23]) + lo + int'($urandom_range(hi - lo, 0));
		if (e < 1)
			e = 1;
		if (e > 254)
			e = 254;
		return {1'($urandom), e[7:0], 23'($urandom)};
	endfunction

	// Drives one operation for one cycle starting 2 ns after a rising edge
	task automatic issue_op(input string name, input logic [31:0] a, input logic [31:0] b,
			input logic sub);
		in_valid = 1'b1;
		in_a = a;
		in_b = b;
		in_sub = sub;
		exp_q.push_back(expected_result(a, b, sub));
		name_q.push_back(name);
		@(posedge clk);
		#2;
		in_valid = 1'b0;
	endtask

	task automatic drain(input int limit);
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < limit) begin
			@(negedge clk);
			waited++;
		end
		if (exp_q.size() != 0) begin
			$display("Timed out with %0d results still pending", exp_q.size());
			$display("Test failed");
			$fatal(1, "drain timeout");
		end
		@(posedge clk);
		#2;
	endtask

	// Scoreboard
	always @(negedge clk) begin
		if (out_valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				$display("Result %h arrived with no operation pending", out_result);
				$display("Test failed");
				$fatal(1, "unexpected out_valid");
			end else begin
				check_value(name_q.pop_front(), exp_q.pop_front(), out_result);
			end
		end
	end

	initial begin
		seed = $urandom(32'h5210);
		clk = 1'b0;
		rst = 1'b1;
		in_valid = 1'b0;
		in_a = '0;
		in_b = '0;
		in_sub = 1'b0;
		repeat (4) begin
			@(posedge clk);
			#1;
			check_value("out_valid in reset", 32'd0, {31'd0, out_valid});
		end
		#1;
		rst = 1'b0;

		// Count rising edges after the sampling edge of an isolated operation
		issue_op("latency", 32'h3fc00000, 32'h40100000, 1'b0);
		edges = 0;
		seen = 1'b0;
		while (!seen && edges < 10) begin
			@(negedge clk);
			if (out_valid === 1'b1) begin
				seen = 1'b1;
			end else begin
				@(posedge clk);
				edges++;
			end
		end
		if (!seen) begin
			$display("No out_valid within 10 cycles of an isolated operation");
			$display("Test failed");
			$fatal(1, "latency timeout");
		end
		check_value("latency", 32'd3, 32'(edges));
		@(posedge clk);
		#2;

		for (int i = 0; i < 300; i++) begin
			x = random_normal();
			y = (i % 2 == 1) ? random_normal() : random_offset(x, -3, 3);
			issue_op("random back to back", x, y, 1'($urandom));
		end
		drain(20);

		issue_op("equal sub", 32'h3f800000, 32'h3f800000, 1'b1);
		issue_op("equal negative sub", 32'hc0400000, 32'hc0400000, 1'b1);
		issue_op("one ulp apart", 32'h3f800000, 32'h3f800001, 1'b1);
		issue_op("across binade", 32'h3f800000, 32'h3f7fffff, 1'b1);
		issue_op("add opposite signs", 32'h3f800000, 32'hbf800000, 1'b0);
		for (int i = 0; i < 30; i++) begin
			x = random_normal();
			y = {x[31], x[30:23], x[22:0] ^ 23'($urandom_range(15, 0))};
			issue_op("near cancellation", x, y, 1'b1);
		end

		issue_op("tie to even down", 32'h3f800000, 32'h33800000, 1'b0);
		issue_op("tie to even up", 32'h3f800001, 32'h33800000, 1'b0);
		issue_op("just past half", 32'h3f800000, 32'h33800001, 1'b0);
		issue_op("below half", 32'h3f800000, 32'h33000000, 1'b0);
		issue_op("sub below half", 32'h3f800000, 32'h33000000, 1'b1);
		issue_op("sub tie", 32'h3f800001, 32'h33800000, 1'b1);
		issue_op("far apart add", 32'h3f800000, 32'h2b800000, 1'b0);
		issue_op("far apart sub", 32'h3f800000, 32'h2b800000, 1'b1);
		issue_op("beyond sig width", 32'h3f800000, 32'h0d800000, 1'b1);
		for (int i = 0; i < 40; i++) begin
			x = random_normal();
			issue_op("sticky region", x, random_offset(x, -30, -20), 1'($urandom));
		end

		issue_op("inf plus finite", 32'h7f800000, 32'h3f800000, 1'b0);
		issue_op("finite minus inf", 32'h3f800000, 32'h7f800000, 1'b1);
		issue_op("inf minus inf", 32'h7f800000, 32'h7f800000, 1'b1);
		issue_op("inf plus neg inf", 32'h7f800000, 32'hff800000, 1'b0);
		issue_op("neg inf plus neg inf", 32'hff800000, 32'hff800000, 1'b0);
		issue_op("nan operand a", 32'h7fc00001, 32'h3f800000, 1'b0);
		issue_op("nan operand b", 32'h3f800000, 32'hff812345, 1'b1);
		issue_op("nan plus inf", 32'h7f800001, 32'h7f800000, 1'b0);
		issue_op("denormal plus one", 32'h00400000, 32'h3f800000, 1'b0);
		issue_op("denormal pair", 32'h00000001, 32'h80000001, 1'b0);
		issue_op("neg denormal minus denormal", 32'h80400000, 32'h00400000, 1'b1);
		issue_op("neg zero plus neg zero", 32'h80000000, 32'h80000000, 1'b0);
		issue_op("overflow max plus max", 32'h7f7fffff, 32'h7f7fffff, 1'b0);
		issue_op("overflow negative", 32'hff7fffff, 32'h7f7fffff, 1'b1);
		issue_op("overflow on rounding", 32'h7f7fffff, 32'h73000000, 1'b0);
		issue_op("underflow to zero", 32'h00800001, 32'h00800000, 1'b1);
		issue_op("underflow partial", 32'h00c00000, 32'h00800001, 1'b1);
		issue_op("underflow negative", 32'h80800001, 32'h80800000, 1'b1);
		drain(20);

		// Reset hits three in-flight operations and none may come out
		for (int i = 0; i < 3; i++)
			issue_op("dropped by reset", random_normal(), random_normal(), 1'b0);
		rst = 1'b1;
		exp_q.delete();
		name_q.delete();
		repeat (2) begin
			@(posedge clk);
			#2;
		end
		rst = 1'b0;
		repeat (8) begin
			@(negedge clk);
			check_value("out_valid after reset", 32'd0, {31'd0, out_valid});
		end
		@(posedge clk);
		#2;
		issue_op("after reset", 32'h40490fdb, 32'h3f800000, 1'b1);
		drain(20);

		$display("Test completed successfully");
		$finish;
	end

endmodule

// File: fp_adder.sv
// Pipelined single-precision FP adder and subtractor with three cycles from input to result
`timescale 1ns/1ns

module fp_adder (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input logic [fp_format_pkg::WORD_W-1:0] in_a,
	input logic [fp_format_pkg::WORD_W-1:0] in_b,
	input logic in_sub,
	output logic out_valid,
	output logic [fp_format_pkg::WORD_W-1:0] out_result
);
	import fp_format_pkg::*;
	import fp_add_pkg::*;

	// Input registers
	logic in_valid_q;
	fp32_t a_q, b_q;
	logic sub_q;

	// Stage one outputs and registers
	logic [SIG_W-1:0] al_sig_large, al_sig_small;
	logic al_eff_sub;
	logic al_sign;
	logic [EXP_W-1:0] al_exp;
	special_t al_special;

	logic s1_valid;
	logic [SIG_W-1:0] s1_sig_large, s1_sig_small;
	logic s1_eff_sub;
	logic s1_sign;
	logic [EXP_W-1:0] s1_exp;
	special_t s1_special;

	// Stage two adder operands and registers
	logic [MANT_W-1:0] add_a, add_b;
	logic [MANT_W-1:0] add_sum;
	logic add_cout;

	logic s2_valid;
	logic [MANT_W-1:0] s2_sum;
	logic s2_cout;
	logic s2_eff_sub;
	logic s2_sign;
	logic [EXP_W-1:0] s2_exp;
	special_t s2_special;

	fp32_t nr_result;

	always_ff @(posedge clk) begin
		if (rst) begin
			in_valid_q <= 1'b0;
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			in_valid_q <= in_valid;
			s1_valid <= in_valid_q;
			s2_valid <= s1_valid;
			out_valid <= s2_valid;
		end
	end

	fp_align fp_align_inst (
		.a(a_q),
		.b(b_q),
		.sub(sub_q),
		.sig_large(al_sig_large),
		.sig_small(al_sig_small),
		.eff_sub(al_eff_sub),
		.sign(al_sign),
		.exp(al_exp),
		.special(al_special)
	);

	// Inverted small operand plus carry in gives the two's complement
	assign add_a = {1'b0, s1_sig_large};
	assign add_b = s1_eff_sub ? ~{1'b0, s1_sig_small} : {1'b0, s1_sig_small};

	prefix_adder #(
		.WIDTH(MANT_W)
	) prefix_adder_inst (
		.a(add_a),
		.b(add_b),
		.cin(s1_eff_sub),
		.sum(add_sum),
		.cout(add_cout)
	);

	fp_normalize_round fp_normalize_round_inst (
		.sum(s2_sum),
		.cout(s2_cout),
		.eff_sub(s2_eff_sub),
		.sign(s2_sign),
		.exp(s2_exp),
		.special(s2_special),
		.result(nr_result)
	);

	// Data path registers
	always_ff @(posedge clk) begin
		a_q <= in_a;
		b_q <= in_b;
		sub_q <= in_sub;

		s1_sig_large <= al_sig_large;
		s1_sig_small <= al_sig_small;
		s1_eff_sub <= al_eff_sub;
		s1_sign <= al_sign;
		s1_exp <= al_exp;
		s1_special <= al_special;

		s2_sum <= add_sum;
		s2_cout <= add_cout;
		s2_eff_sub <= s1_eff_sub;
		s2_sign <= s1_sign;
		s2_exp <= s1_exp;
		s2_special <= s1_special;

		out_result <= nr_result;
	end

endmodule

// File: fp_normalize_round.sv
// FP adder stage three normalizes, rounds to nearest even and packs the result
`timescale 1ns/1ns

module fp_normalize_round (
	input logic [fp_add_pkg::MANT_W-1:0] sum,
	input logic cout,
	input logic eff_sub,
	input logic sign,
	input logic [fp_format_pkg::EXP_W-1:0] exp,
	input fp_add_pkg::special_t special,
	output fp_format_pkg::fp32_t result
);
	import fp_format_pkg::*;
	import fp_add_pkg::*;

	function automatic logic [SHAMT_W-1:0] count_lz(input logic [SIG_W-1:0] v);
		logic found;
		count_lz = SHAMT_W'(SIG_W);
		found = 1'b0;
		for (int k = SIG_W - 1; k >= 0; k--) begin
			if (!found && v[k]) begin
				count_lz = SHAMT_W'(SIG_W - 1 - k);
				found = 1'b1;
			end
		end
	endfunction

	logic carry;
	logic zero_sum;
	logic [SIG_W-1:0] low_sig;
	logic [SHAMT_W-1:0] lz;
	logic signed [EXP_IW-1:0] exp_ext;
	logic signed [EXP_IW-1:0] exp_norm;
	logic signed [EXP_IW-1:0] exp_rnd;
	logic [SIG_W-1:0] norm;
	logic lsb, guard_bit, round_bit, sticky_bit;
	logic round_up;
	logic [FRAC_W+1:0] mant_rnd;

	// On subtraction the carry out only marks a borrow-free difference
	assign carry = sum[MANT_W-1] | (cout & ~eff_sub);
	assign zero_sum = (sum == '0);
	assign low_sig = sum[SIG_W-1:0];
	assign lz = count_lz(low_sig);
	assign exp_ext = EXP_IW'(exp);

	always_comb begin
		if (carry) begin
			// Shift right one with the dropped bit folded into sticky
			norm = {sum[MANT_W-1:2], |sum[1:0]};
			exp_norm = exp_ext + EXP_IW'(1);
		end else begin
			norm = low_sig << lz;
			exp_norm = exp_ext - EXP_IW'(lz);
		end
	end

	assign lsb = norm[3];
	assign guard_bit = norm[2];
	assign round_bit = norm[1];
	assign sticky_bit = norm[0];

	// Ties go to the even significand
	assign round_up = guard_bit & (round_bit | sticky_bit | lsb);
	assign mant_rnd = {1'b0, norm[SIG_W-1:3]} + (FRAC_W + 2)'(round_up);

	// Rounding overflow leaves 1.0 whose fraction bits are already zero
	assign exp_rnd = exp_norm + EXP_IW'(mant_rnd[FRAC_W+1]);

	always_comb begin
		result.raw = '0;
		case (special)
			SP_NAN: begin
				result.raw = QNAN;
			end
			SP_INF: begin
				result.f.sign = sign;
				result.f.exp = EXP_W'(EXP_MAX);
			end
			SP_ZERO: begin
				result.f.sign = sign;
			end
			default: begin
				if (zero_sum) begin
					// Exact cancellation is +0
					result.raw = '0;
				end else if (exp_rnd >= EXP_MAX) begin
					result.f.sign = sign;
					result.f.exp = EXP_W'(EXP_MAX);
				end else if (exp_rnd <= 0) begin
					// Below the normal range flush to signed zero
					result.f.sign = sign;
				end else begin
					result.f.sign = sign;
					result.f.exp = exp_rnd[EXP_W-1:0];
					result.f.frac = mant_rnd[FRAC_W-1:0];
				end
			end
		endcase
	end

endmodule

// File: prefix_adder.sv
// Han-Carlson parallel-prefix adder of any width with carry in and carry out
`timescale 1ns/1ns

module prefix_adder #(
	parameter int WIDTH = 28
) (
	input logic [WIDTH-1:0] a,
	input logic [WIDTH-1:0] b,
	input logic cin,
	output logic [WIDTH-1:0] sum,
	output logic cout
);

	localparam int LEVELS = $clog2(WIDTH);

	// Black cell merges generate and propagate of two spans
	function automatic logic [1:0] black_cell(
		input logic g_hi,
		input logic p_hi,
		input logic g_lo,
		input logic p_lo
	);
		black_cell = {g_hi | (p_hi & g_lo), p_hi & p_lo};
	endfunction

	// Grey cell computes generate only
	function automatic logic grey_cell(
		input logic g_hi,
		input logic p_hi,
		input logic g_lo
	);
		grey_cell = g_hi | (p_hi & g_lo);
	endfunction

	// Position 0 holds the carry in and position i+1 holds bit i
	logic [WIDTH:0] p;
	logic [WIDTH:0] g;
	logic [LEVELS:0][WIDTH-1:0] gt;
	logic [LEVELS:0][WIDTH-1:0] pt;
	logic [WIDTH-1:0] c;

	assign p = {a ^ b, 1'b0};
	assign g = {a & b, cin};

	assign gt[0] = g[WIDTH-1:0];
	assign pt[0] = p[WIDTH-1:0];

	genvar lvl, i;
	generate
		// Kogge-Stone over the odd positions only
		for (lvl = 1; lvl <= LEVELS; lvl++) begin : g_level
			localparam int D = 1 << (lvl - 1);
			for (i = 0; i < WIDTH; i++) begin : g_pos
				if ((i % 2 == 1) && (i >= D)) begin : g_black
					assign {gt[lvl][i], pt[lvl][i]} = black_cell(
						gt[lvl-1][i], pt[lvl-1][i],
						gt[lvl-1][i-D], pt[lvl-1][i-D]);
				end else begin : g_pass
					assign gt[lvl][i] = gt[lvl-1][i];
					assign pt[lvl][i] = pt[lvl-1][i];
				end
			end
		end

		// Extra grey level fills the even carries from their odd neighbour
		for (i = 0; i < WIDTH; i++) begin : g_carry
			if ((i % 2 == 1) || (i == 0)) begin : g_odd
				assign c[i] = gt[LEVELS][i];
			end else begin : g_even
				assign c[i] = grey_cell(g[i], p[i], gt[LEVELS][i-1]);
			end
		end
	endgenerate

	assign sum = p[WIDTH:1] ^ c;
	assign cout = g[WIDTH] | (p[WIDTH] & c[WIDTH-1]);

endmodule

// File: fp_align.sv
// FP adder stage one unpacks operands, classifies specials, orders by magnitude and aligns
`timescale 1ns/1ns

module fp_align (
	input fp_format_pkg::fp32_t a,
	input fp_format_pkg::fp32_t b,
	input logic sub,
	output logic [fp_add_pkg::SIG_W-1:0] sig_large,
	output logic [fp_add_pkg::SIG_W-1:0] sig_small,
	output logic eff_sub,
	output logic sign,
	output logic [fp_format_pkg::EXP_W-1:0] exp,
	output fp_add_pkg::special_t special
);
	import fp_format_pkg::*;
	import fp_add_pkg::*;

	logic sign_a, sign_b;
	logic zero_a, zero_b;
	logic inf_a, inf_b;
	logic nan_a, nan_b;
	logic [FRAC_W-1:0] frac_a, frac_b;
	logic [SIG_W-1:0] sig_a, sig_b;
	logic a_larger;
	logic [EXP_W-1:0] exp_s;
	logic [EXP_W-1:0] exp_diff;
	logic [SIG_W-1:0] sig_s;
	logic [SHAMT_W-1:0] shamt;
	logic [SIG_W-1:0] shifted;
	logic [SIG_W-1:0] lost_mask;
	logic sticky;

	// Subtraction is addition with b negated
	assign sign_a = a.f.sign;
	assign sign_b = b.f.sign ^ sub;
	assign eff_sub = sign_a ^ sign_b;

	// Zero exponent covers true zeros and denormals
	assign zero_a = (a.f.exp == '0);
	assign zero_b = (b.f.exp == '0);
	assign inf_a = (a.f.exp == EXP_W'(EXP_MAX)) && (a.f.frac == '0);
	assign inf_b = (b.f.exp == EXP_W'(EXP_MAX)) && (b.f.frac == '0);
	assign nan_a = (a.f.exp == EXP_W'(EXP_MAX)) && (a.f.frac != '0);
	assign nan_b = (b.f.exp == EXP_W'(EXP_MAX)) && (b.f.frac != '0);

	assign frac_a = zero_a ? '0 : a.f.frac;
	assign frac_b = zero_b ? '0 : b.f.frac;
	assign sig_a = {~zero_a, frac_a, 3'b000};
	assign sig_b = {~zero_b, frac_b, 3'b000};

	// Magnitude order compares exponent first then fraction
	assign a_larger = {a.f.exp, frac_a} >= {b.f.exp, frac_b};

	assign exp = a_larger ? a.f.exp : b.f.exp;
	assign exp_s = a_larger ? b.f.exp : a.f.exp;
	assign sig_large = a_larger ? sig_a : sig_b;
	assign sig_s = a_larger ? sig_b : sig_a;

	// Saturate the shift so far-apart operands collapse into sticky
	assign exp_diff = exp - exp_s;
	assign shamt = (exp_diff >= EXP_W'(SIG_W)) ? SHAMT_W'(SIG_W) : exp_diff[SHAMT_W-1:0];

	assign shifted = sig_s >> shamt;
	assign lost_mask = ~({SIG_W{1'b1}} << shamt);
	assign sticky = |(sig_s & lost_mask);
	assign sig_small = {shifted[SIG_W-1:1], shifted[0] | sticky};

	always_comb begin
		if (nan_a || nan_b || (inf_a && inf_b && eff_sub)) begin
			special = SP_NAN;
			sign = 1'b0;
		end else if (inf_a) begin
			special = SP_INF;
			sign = sign_a;
		end else if (inf_b) begin
			special = SP_INF;
			sign = sign_b;
		end else if (zero_a && zero_b) begin
			// Only -0 plus -0 stays negative
			special = SP_ZERO;
			sign = sign_a & sign_b;
		end else begin
			special = SP_NONE;
			sign = a_larger ? sign_a : sign_b;
		end
	end

endmodule

// File: fp_add_pkg.sv
// Internal datapath widths and the special-result class of the FP adder
package fp_add_pkg;

	// Hidden bit, fraction, then guard, round and sticky
	localparam int SIG_W = fp_format_pkg::FRAC_W + 4;

	// One bit of headroom for the carry of an addition
	localparam int MANT_W = SIG_W + 1;

	// Alignment shift and leading-zero count up to SIG_W
	localparam int SHAMT_W = $clog2(SIG_W + 1);

	// Signed exponent with room for normalize overshoot either way
	localparam int EXP_IW = fp_format_pkg::EXP_W + 2;

	// Result class decided in stage one and carried to stage three
	typedef enum logic [1:0] {
		SP_NONE,
		SP_ZERO,
		SP_INF,
		SP_NAN
	} special_t;

endpackage

// File: fp_format_pkg.sv
// Single-precision word layout, exponent bias and special encodings
package fp_format_pkg;

	// Field widths of a binary32 word
	localparam int EXP_W = 8;
	localparam int FRAC_W = 23;
	localparam int WORD_W = 1 + EXP_W + FRAC_W;

	localparam int EXP_BIAS = 127;

	// All-ones exponent reserved for infinity and NaN
	localparam int EXP_MAX = 2 * EXP_BIAS + 1;

	// Canonical quiet NaN is positive with the top fraction bit set
	localparam logic [WORD_W-1:0] QNAN = {
		1'b0,
		{EXP_W{1'b1}},
		1'b1,
		{(FRAC_W - 1){1'b0}}
	};

	typedef struct packed {
		logic sign;
		logic [EXP_W-1:0] exp;
		logic [FRAC_W-1:0] frac;
	} fp32_fields_t;

	// Same 32 bits seen either as a raw word or as its fields
	typedef union packed {
		logic [WORD_W-1:0] raw;
		fp32_fields_t f;
	} fp32_t;

endpackage
